/* vlog.f */
+incdir+design
design/mxdp_pkg.sv
design/mx_block_split.sv
design/mant_dot_pipe.sv
design/mx_block_join.sv
design/mxint_dot_product.sv
bench/mxdp_properties.sv
bench/mxdp_checker.sv
bench/tb_mxint_dot_product.sv

/* Bender.yml */
package:
  name: mxint_dot_product

sources:
  - include_dirs:
      - design
    files:
      - design/mxdp_pkg.sv
      - design/mx_block_split.sv
      - design/mant_dot_pipe.sv
      - design/mx_block_join.sv
      - design/mxint_dot_product.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/mxdp_properties.sv
      - bench/mxdp_checker.sv
      - bench/tb_mxint_dot_product.sv

/* bench/tb_mxint_dot_product.sv */
`timescale 1ns/1ns
`include "mxdp_defs.svh"

module tb_mxint_dot_product;

  import mxdp_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int N_RANDOM     = 40;
  localparam int TOTAL_BLOCKS = 4 + 3 + 2 * N_RANDOM + 1; // directed, extreme, random, latency.

  logic        clk;
  logic        arst_n;
  mx_block_t   data_in;
  logic        data_in_valid;
  logic        data_in_ready;
  mx_block_t   weight;
  logic        weight_valid;
  logic        weight_ready;
  mx_result_t  result;
  logic        result_valid;
  logic        result_ready;
  int          chk_results;
  int          chk_errors;
  int          tb_errors;
  int          tests_passed;
  int          tests_failed;
  logic        stall_seen;
  logic [31:0] lfsr;
  mx_block_t   stim_data [$];
  mx_block_t   stim_weight [$];
  int          data_gap [$];
  int          weight_gap [$];

  mxint_dot_product dut_i (.*);
  mxdp_checker chk_i (.*, .results(chk_results), .errors(chk_errors));

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (arst_n && !data_in_ready && !weight_ready) stall_seen = 1'b1; // both inputs blocked.
  end

  // ----------------------------------------
  // random source and block builders
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2 and 1.
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic mx_block_t random_block();
    mx_block_t b;
    for (int i = 0; i < `MXDP_BLOCK_SIZE; i++) begin
      b.man[i] = man_t'(take_bits(`MXDP_MAN_W));
    end
    b.exp = exp_t'(take_bits(`MXDP_EXP_W));
    return b;
  endfunction

  function automatic mx_block_t ramp_block(input int e, input int start, input int step);
    mx_block_t b;
    for (int i = 0; i < `MXDP_BLOCK_SIZE; i++) begin
      b.man[i] = man_t'(start + i * step);
    end
    b.exp = exp_t'(e);
    return b;
  endfunction

  function automatic mx_block_t alternating_block(input int e);
    mx_block_t b;
    for (int i = 0; i < `MXDP_BLOCK_SIZE; i++) begin
      b.man[i] = (i % 2 == 0) ? man_t'(127) : man_t'(-128);
    end
    b.exp = exp_t'(e);
    return b;
  endfunction

  function automatic int total_errors();
    return chk_errors + tb_errors + dut_i.join_i.props_i.assert_failures;
  endfunction

  // ----------------------------------------
  // stream drivers
  // ----------------------------------------
  task automatic add_pair(input mx_block_t a, input mx_block_t w, input bit gaps);
    stim_data.push_back(a);
    stim_weight.push_back(w);
    data_gap.push_back(gaps ? int'(take_bits(2)) : 0); // idle cycles before the block.
    weight_gap.push_back(gaps ? int'(take_bits(2)) : 0);
  endtask

  task automatic drive_data();
    while (stim_data.size() > 0) begin
      repeat (data_gap.pop_front()) begin
        data_in_valid <= 1'b0;
        @(negedge clk);
      end
      data_in       <= stim_data.pop_front();
      data_in_valid <= 1'b1;
      do @(posedge clk); while (!data_in_ready); // held until the handshake.
      @(negedge clk);
    end
    data_in_valid <= 1'b0;
  endtask

  task automatic drive_weight();
    while (stim_weight.size() > 0) begin
      repeat (weight_gap.pop_front()) begin
        weight_valid <= 1'b0;
        @(negedge clk);
      end
      weight       <= stim_weight.pop_front();
      weight_valid <= 1'b1;
      do @(posedge clk); while (!weight_ready);
      @(negedge clk);
    end
    weight_valid <= 1'b0;
  endtask

  task automatic drive_result_ready(input bit random_ready, input int target);
    while (chk_results < target) begin
      result_ready <= random_ready ? (take_bits(2) == 0) : 1'b1; // one cycle in four.
      @(negedge clk);
    end
    result_ready <= 1'b1;
  endtask

  task automatic run_streams(input bit random_ready);
    int target;
    target = chk_results + stim_data.size();
    fork
      drive_data();
      drive_weight();
      drive_result_ready(random_ready, target);
    join
  endtask

  task automatic check_bit(input string name, input logic expected, input logic got);
    if (got !== expected) begin
      tb_errors++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, expected, got);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (total_errors() == err_before) begin
      tests_passed++;
      $display("test %s: ok, %0d results so far", name, chk_results);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total_errors() - err_before);
    end
  endtask

  task automatic check_latency();
    int waited;
    int target;
    target = chk_results + 1;
    data_in       <= random_block();
    weight        <= random_block();
    data_in_valid <= 1'b1;
    weight_valid  <= 1'b1;
    @(posedge clk);
    if (!data_in_ready || !weight_ready) begin
      tb_errors++;
      $display("latency: the two blocks were not accepted at the same edge");
    end
    @(negedge clk);
    data_in_valid <= 1'b0;
    weight_valid  <= 1'b0;
    waited = 1;
    while (!result_valid && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (waited != 4) begin
      tb_errors++;
      $display("[FAIL] %0t result_valid latency expected 4 got %0d", $time, waited);
    end
    while (chk_results < target) @(negedge clk);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    mx_block_t a_blk;
    mx_block_t w_blk;
    int        err_before;
    clk           = 1'b0;
    arst_n        <= 1'b0;
    data_in       = '0;
    data_in_valid = 1'b0;
    weight        = '0;
    weight_valid  = 1'b0;
    result_ready  = 1'b1;
    lfsr          = 32'he27a;
    tb_errors     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    stall_seen    = 1'b0;
    repeat (2) @(negedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    err_before = total_errors();
    check_bit("result_valid", 1'b0, result_valid);
    check_bit("data_in_ready", 1'b1, data_in_ready);
    check_bit("weight_ready", 1'b1, weight_ready);
    report_test("reset", err_before);

    err_before = total_errors();
    add_pair(ramp_block(-3, 1, 1), ramp_block(5, -6, 2), 1'b0);
    add_pair(ramp_block(-128, -20, 7), ramp_block(-128, 9, -3), 1'b0);
    add_pair(ramp_block(127, 0, 11), ramp_block(-1, 40, -15), 1'b0);
    add_pair(ramp_block(-7, -1, -1), ramp_block(-64, 3, 5), 1'b0);
    run_streams(1'b0);
    report_test("directed", err_before);

    err_before = total_errors();
    add_pair(ramp_block(0, -128, 0), ramp_block(0, -128, 0), 1'b0); // largest positive sum.
    add_pair(ramp_block(3, 127, 0), ramp_block(-4, -128, 0), 1'b0);
    add_pair(alternating_block(-100), alternating_block(100), 1'b0);
    run_streams(1'b0);
    report_test("extreme values", err_before);

    err_before = total_errors();
    for (int i = 0; i < N_RANDOM; i++) begin
      a_blk = random_block();
      w_blk = random_block();
      add_pair(a_blk, w_blk, 1'b1);
    end
    run_streams(1'b0);
    report_test("independent streams", err_before);

    err_before = total_errors();
    for (int i = 0; i < N_RANDOM; i++) begin
      a_blk = random_block();
      w_blk = random_block();
      add_pair(a_blk, w_blk, 1'b0);
    end
    stall_seen = 1'b0;
    run_streams(1'b1);
    if (!stall_seen) begin
      tb_errors++;
      $display("back-pressure: the input readies never fell while the pipeline was full");
    end
    report_test("back-pressure", err_before);

    err_before = total_errors();
    check_latency();
    report_test("latency", err_before);

    $display("tests passed %0d, failed %0d, results checked %0d, errors %0d",
             tests_passed, tests_failed, chk_results, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(TOTAL_BLOCKS * 40 * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", TOTAL_BLOCKS * 40);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* bench/mxdp_checker.sv */
`timescale 1ns/1ns
`include "mxdp_defs.svh"

module mxdp_checker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mxdp_pkg::mx_block_t  data_in,
  input  logic                 data_in_valid,
  input  logic                 data_in_ready,
  input  mxdp_pkg::mx_block_t  weight,
  input  logic                 weight_valid,
  input  logic                 weight_ready,
  input  mxdp_pkg::mx_result_t result,
  input  logic                 result_valid,
  input  logic                 result_ready,
  output int                   results,
  output int                   errors
);

  import mxdp_pkg::*;

  mx_block_t  data_q [$];
  mx_block_t  weight_q [$];
  mx_result_t expected;

  // full precision sum of products; the two exponents simply add.
  function automatic mx_result_t ref_dot(input mx_block_t a, input mx_block_t w);
    mx_result_t r;
    int         acc;
    acc = 0;
    for (int i = 0; i < `MXDP_BLOCK_SIZE; i++) begin
      acc += int'($signed(a.man[i])) * int'($signed(w.man[i]));
    end
    r.sum = sum_t'(acc);
    r.exp = out_exp_t'(int'($signed(a.exp)) + int'($signed(w.exp)));
    return r;
  endfunction

  initial begin
    results = 0;
    errors  = 0;
  end

  always @(posedge clk) begin
    if (arst_n) begin
      if (data_in_valid && data_in_ready) data_q.push_back(data_in);
      if (weight_valid && weight_ready) weight_q.push_back(weight);
      if (result_valid && result_ready) begin
        results++;
        if (data_q.size() == 0 || weight_q.size() == 0) begin
          errors++;
          $display("%0t: a result came out with no block pair waiting for it", $time);
        end else begin
          expected = ref_dot(data_q.pop_front(), weight_q.pop_front()); // nth with nth.
          if (result.sum !== expected.sum) begin
            errors++;
            $display("[FAIL] %0t result.sum expected %0d got %0d", $time, expected.sum,
                     result.sum);
          end
          if (result.exp !== expected.exp) begin
            errors++;
            $display("[FAIL] %0t result.exp expected %0d got %0d", $time, expected.exp,
                     result.exp);
          end
        end
      end
    end
  end

endmodule

/* bench/mxdp_properties.sv */
`timescale 1ns/1ns

module mxdp_properties (
  input logic                 clk,
  input logic                 arst_n,
  input mxdp_pkg::mx_result_t result,
  input logic                 result_valid,
  input logic                 result_ready,
  input logic                 sum_ready,
  input logic                 act_exp_ready,
  input logic                 wgt_exp_ready
);

  int assert_failures = 0;

  reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !result_valid)
    else begin
      assert_failures++;
      $error("result_valid is high while arst_n is low");
    end

  held_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
      assert_failures++;
      $error("a held result changed or lost its valid");
    end

  readies_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown({sum_ready, act_exp_ready, wgt_exp_ready}))
    else begin
      assert_failures++;
      $error("an input ready of the join is unknown");
    end

endmodule

bind mx_block_join mxdp_properties props_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .result        (result),
  .result_valid  (result_valid),
  .result_ready  (result_ready),
  .sum_ready     (sum_ready),
  .act_exp_ready (act_exp_ready),
  .wgt_exp_ready (wgt_exp_ready)
);

/* design/mxint_dot_product.sv */
`timescale 1ns/1ns

module mxint_dot_product (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mxdp_pkg::mx_block_t  data_in,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,
  input  mxdp_pkg::mx_block_t  weight,
  input  logic                 weight_valid,
  output logic                 weight_ready,
  output mxdp_pkg::mx_result_t result,
  output logic                 result_valid,
  input  logic                 result_ready
);

  import mxdp_pkg::*;

  man_block_t act_man;
  logic       act_man_valid;
  logic       act_man_ready;
  exp_t       act_exp;
  logic       act_exp_valid;
  logic       act_exp_ready;

  man_block_t wgt_man;
  logic       wgt_man_valid;
  logic       wgt_man_ready;
  exp_t       wgt_exp;
  logic       wgt_exp_valid;
  logic       wgt_exp_ready;

  sum_t       man_sum;
  logic       man_sum_valid;
  logic       man_sum_ready;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  mx_block_split act_split_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .blk       (data_in),
    .blk_valid (data_in_valid),
    .blk_ready (data_in_ready),
    .man       (act_man),
    .man_valid (act_man_valid),
    .man_ready (act_man_ready),
    .exp       (act_exp),
    .exp_valid (act_exp_valid),
    .exp_ready (act_exp_ready)
  );

  mx_block_split wgt_split_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .blk       (weight),
    .blk_valid (weight_valid),
    .blk_ready (weight_ready),
    .man       (wgt_man),
    .man_valid (wgt_man_valid),
    .man_ready (wgt_man_ready),
    .exp       (wgt_exp),
    .exp_valid (wgt_exp_valid),
    .exp_ready (wgt_exp_ready)
  );

  // ----------------------------------------
  // mantissa datapath and output join
  // ----------------------------------------
  mant_dot_pipe dot_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .act       (act_man),
    .act_valid (act_man_valid),
    .act_ready (act_man_ready),
    .wgt       (wgt_man),
    .wgt_valid (wgt_man_valid),
    .wgt_ready (wgt_man_ready),
    .sum       (man_sum),
    .sum_valid (man_sum_valid),
    .sum_ready (man_sum_ready)
  );

  mx_block_join join_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .sum           (man_sum),
    .sum_valid     (man_sum_valid),
    .sum_ready     (man_sum_ready),
    .act_exp       (act_exp),
    .act_exp_valid (act_exp_valid),
    .act_exp_ready (act_exp_ready),
    .wgt_exp       (wgt_exp),
    .wgt_exp_valid (wgt_exp_valid),
    .wgt_exp_ready (wgt_exp_ready),
    .result        (result),
    .result_valid  (result_valid),
    .result_ready  (result_ready)
  );

endmodule

/* design/mx_block_join.sv */
`timescale 1ns/1ns

module mx_block_join (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mxdp_pkg::sum_t       sum,
  input  logic                 sum_valid,
  output logic                 sum_ready,
  input  mxdp_pkg::exp_t       act_exp,
  input  logic                 act_exp_valid,
  output logic                 act_exp_ready,
  input  mxdp_pkg::exp_t       wgt_exp,
  input  logic                 wgt_exp_valid,
  output logic                 wgt_exp_ready,
  output mxdp_pkg::mx_result_t result,
  output logic                 result_valid,
  input  logic                 result_ready
);

  import mxdp_pkg::*;

  logic     out_free;
  logic     fire;
  out_exp_t exp_sum;

  // ----------------------------------------
  // three way handshake
  // ----------------------------------------
  assign out_free = !result_valid || result_ready;
  assign fire     = sum_valid && act_exp_valid && wgt_exp_valid && out_free;

  assign sum_ready     = fire;
  assign act_exp_ready = fire;
  assign wgt_exp_ready = fire;

  assign exp_sum = out_exp_t'(act_exp) + out_exp_t'(wgt_exp); // cannot overflow.

  // ----------------------------------------
  // result register
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else if (out_free) begin
      result_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      result.exp <= exp_sum;
      result.sum <= sum;
    end
  end

endmodule

/* design/mant_dot_pipe.sv */
`timescale 1ns/1ns
`include "mxdp_defs.svh"

module mant_dot_pipe (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mxdp_pkg::man_block_t act,
  input  logic                 act_valid,
  output logic                 act_ready,
  input  mxdp_pkg::man_block_t wgt,
  input  logic                 wgt_valid,
  output logic                 wgt_ready,
  output mxdp_pkg::sum_t       sum,
  output logic                 sum_valid,
  input  logic                 sum_ready
);

  import mxdp_pkg::*;

  localparam int N      = `MXDP_BLOCK_SIZE;
  localparam int PROD_W = 2 * `MXDP_MAN_W;
  localparam int LEVELS = $clog2(N);
  localparam int LEAVES = 1 << LEVELS; // tree is padded to a power of two.

  logic                     take;
  logic                     prod_valid;
  logic                     prod_adv;
  logic                     sum_adv;
  logic signed [PROD_W-1:0] prod_q [N];
  sum_t                     tree [LEVELS+1][LEAVES];

  // ----------------------------------------
  // stall control
  // ----------------------------------------
  assign sum_adv  = !sum_valid || sum_ready;
  assign prod_adv = !prod_valid || sum_adv;

  // both streams are consumed together or not at all.
  assign take      = act_valid && wgt_valid && prod_adv;
  assign act_ready = wgt_valid && prod_adv;
  assign wgt_ready = act_valid && prod_adv;

  // ----------------------------------------
  // stage one, products
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_valid <= 1'b0;
    end else if (prod_adv) begin
      prod_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      for (int i = 0; i < N; i++) begin
        prod_q[i] <= $signed(act[i]) * $signed(wgt[i]);
      end
    end
  end

  // ----------------------------------------
  // stage two, adder tree
  // ----------------------------------------
  always_comb begin
    for (int l = 0; l <= LEVELS; l++) begin
      for (int i = 0; i < LEAVES; i++) begin
        tree[l][i] = '0;
      end
    end
    for (int i = 0; i < N; i++) begin
      tree[0][i] = sum_t'(prod_q[i]); // sign extension of each product.
    end
    for (int l = 0; l < LEVELS; l++) begin
      for (int i = 0; i < (LEAVES >> (l + 1)); i++) begin
        tree[l+1][i] = tree[l][2*i] + tree[l][2*i+1];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_valid <= 1'b0;
    end else if (sum_adv) begin
      sum_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_adv && prod_valid) begin
      sum <= tree[LEVELS][0];
    end
  end

endmodule

/* design/mx_block_split.sv */
`timescale 1ns/1ns
`include "mxdp_defs.svh"

module mx_block_split (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mxdp_pkg::mx_block_t  blk,
  input  logic                 blk_valid,
  output logic                 blk_ready,
  output mxdp_pkg::man_block_t man,
  output logic                 man_valid,
  input  logic                 man_ready,
  output mxdp_pkg::exp_t       exp,
  output logic                 exp_valid,
  input  logic                 exp_ready
);

  import mxdp_pkg::*;

  localparam int DEPTH = `MXDP_EXP_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             accept;
  logic             man_free;
  logic             fifo_full;
  logic             exp_pop;
  exp_t             exp_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign man_free  = !man_valid || man_ready; // slice is empty or drains this cycle.
  assign fifo_full = (count == CNT_W'(DEPTH));
  assign blk_ready = man_free && !fifo_full;
  assign accept    = blk_valid && blk_ready;

  // ----------------------------------------
  // mantissa register slice
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      man_valid <= 1'b0;
    end else if (man_free) begin
      man_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      man <= blk.man;
    end
  end

  // ----------------------------------------
  // exponent FIFO
  // ----------------------------------------
  assign exp_valid = (count != '0);
  assign exp       = exp_mem[rd_ptr];
  assign exp_pop   = exp_valid && exp_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      exp_mem[wr_ptr] <= blk.exp;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (exp_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({accept, exp_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // push and pop together leave it as is.
      endcase
    end
  end

endmodule

/* design/mxdp_pkg.sv */
`include "mxdp_defs.svh"

package mxdp_pkg;

  // ----------------------------------------
  // scalar fields
  // ----------------------------------------
  typedef logic signed [`MXDP_MAN_W-1:0]     man_t;
  typedef logic signed [`MXDP_EXP_W-1:0]     exp_t;
  typedef logic signed [`MXDP_SUM_W-1:0]     sum_t;
  typedef logic signed [`MXDP_OUT_EXP_W-1:0] out_exp_t;

  // ----------------------------------------
  // blocks and results
  // ----------------------------------------
  typedef man_t [`MXDP_BLOCK_SIZE-1:0] man_block_t;

  typedef struct packed {
    exp_t       exp; // shared by every mantissa of the block.
    man_block_t man;
  } mx_block_t;

  typedef struct packed {
    out_exp_t exp;
    sum_t     sum; // not normalised.
  } mx_result_t;

endpackage

/* design/mxdp_defs.svh */
`ifndef MXDP_DEFS_SVH
`define MXDP_DEFS_SVH

// ----------------------------------------
// block geometry
// ----------------------------------------
`define MXDP_BLOCK_SIZE 6 // mantissas per block.

// ----------------------------------------
// field widths
// ----------------------------------------
`define MXDP_MAN_W 8 // signed mantissa.
`define MXDP_EXP_W 8 // signed shared exponent.
`define MXDP_SUM_W (2 * `MXDP_MAN_W + $clog2(`MXDP_BLOCK_SIZE)) // full precision sum.
`define MXDP_OUT_EXP_W (`MXDP_EXP_W + 1) // sum of two exponents.

// covers the mantissa slice, both pipeline stages and the result register.
`define MXDP_EXP_FIFO_DEPTH 4

`endif
